//--- logic/rename_pkg.sv
//////////////////////////////
// rename package
// sizes and index types shared by
// the rename map, register file and retire map
//////////////////////////////
`default_nettype none

package rename_pkg;

    // data path
    localparam int xlen = 32;

    // physical registers, entry 0 is hardwired zero
    localparam int prf_size = 16;
    localparam int prf_len  = 4;

    // architectural registers
    localparam int arch_size = 8;
    localparam int arch_len  = 3;

    typedef logic [prf_len-1:0]  preg_t;      // physical index
    typedef logic [arch_len-1:0] areg_t;      // architectural index
    typedef logic [xlen-1:0]     word_t;      // data word
    typedef logic [prf_size-1:0] preg_mask_t; // one bit per physical reg

endpackage

`default_nettype wire

//--- logic/prf_port_if.sv
//////////////////////////////
// rename map to register file port
// operand lookups and allocation of a free register
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface prf_port_if import rename_pkg::*; ();

    // lookups from the speculative map
    preg_t opa_preg;
    preg_t opb_preg;
    logic  alloc;       // one cycle, takes free_preg

    // answers from the file
    preg_t free_preg;   // lowest free, nonzero
    logic  has_free;
    logic  opa_ready;
    word_t opa_value;
    logic  opb_ready;
    word_t opb_value;

    modport map_side (
        output opa_preg, opb_preg, alloc,
        input  free_preg, has_free, opa_ready, opa_value, opb_ready, opb_value
    );

    modport file_side (
        input  opa_preg, opb_preg, alloc,
        output free_preg, has_free, opa_ready, opa_value, opb_ready, opb_value
    );

endinterface

`default_nettype wire

//--- logic/recovery_if.sv
//////////////////////////////
// commit and recovery bus
// driven by the retire map toward file and map
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface recovery_if import rename_pkg::*; ();

    logic                      release_valid;  // free release_preg this edge
    preg_t                     release_preg;
    logic                      mis_pred;       // restore strobe
    preg_mask_t                committed_free;
    preg_t [arch_size-1:0]     committed_map;

    modport retire_side (
        output release_valid, release_preg, mis_pred, committed_free, committed_map
    );

    // file side takes the committed free mask
    modport file_side (
        input release_valid, release_preg, mis_pred, committed_free
    );

    // map side takes the committed mapping
    modport map_side (
        input mis_pred, committed_map
    );

endinterface

`default_nettype wire

//--- logic/rename_map.sv
//////////////////////////////
// speculative rename map
// source lookup and destination allocation at dispatch
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rename_map import rename_pkg::*; (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          dispatch_valid,
    input  wire areg_t         dispatch_dest,
    input  wire areg_t         dispatch_src_a,
    input  wire areg_t         dispatch_src_b,
    output logic               dispatch_stall,
    output preg_t              dispatch_preg,
    prf_port_if.map_side       port,
    recovery_if.map_side       recovery
);

    preg_t spec_map [arch_size];   // arch -> phys, speculative
    logic  dest_nonzero;
    logic  take;

    //////////////////////////////
    // lookup and allocation
    //////////////////////////////

    assign dest_nonzero = (dispatch_dest != '0);

    // sources see the map before this edge
    assign port.opa_preg = spec_map[dispatch_src_a];
    assign port.opb_preg = spec_map[dispatch_src_b];

    assign dispatch_stall = dest_nonzero && !port.has_free;
    assign dispatch_preg  = dest_nonzero ? port.free_preg : '0;   // dest 0 gets nothing

    // recovery wins over dispatch
    assign take       = dispatch_valid && dest_nonzero && port.has_free
                        && !recovery.mis_pred;
    assign port.alloc = take;

    //////////////////////////////
    // map update
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_size; i++) begin
                spec_map[i] <= '0;
            end
        end else if (recovery.mis_pred) begin
            // fall back to what has committed
            for (int i = 0; i < arch_size; i++) begin
                spec_map[i] <= recovery.committed_map[i];
            end
        end else if (take) begin
            spec_map[dispatch_dest] <= port.free_preg;
        end
    end

endmodule

`default_nettype wire

//--- logic/prf.sv
//////////////////////////////
// physical register file
// values, ready bits and free bitmap
// with completion bypass on operand reads
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module prf import rename_pkg::*; (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          cdb_valid,
    input  wire preg_t         cdb_preg,
    input  wire word_t         cdb_result,
    prf_port_if.file_side      port,
    recovery_if.file_side      recovery
);

    word_t      values [prf_size];
    preg_mask_t ready;
    preg_mask_t free;

    preg_t      lowest_free;
    logic       cdb_write;
    logic       hit_a;
    logic       hit_b;

    //////////////////////////////
    // free register select
    //////////////////////////////

    // walk down so the lowest free index is the one left standing
    always_comb begin
        lowest_free = '0;
        for (int i = prf_size - 1; i > 0; i--) begin
            if (free[i]) begin
                lowest_free = preg_t'(i);
            end
        end
    end

    assign port.free_preg = lowest_free;
    assign port.has_free  = |free[prf_size-1:1];   // entry 0 never counts

    //////////////////////////////
    // operand reads
    //////////////////////////////

    // no write to reg 0 or during a restore
    assign cdb_write = cdb_valid && (cdb_preg != '0) && !recovery.mis_pred;

    assign hit_a = cdb_write && (port.opa_preg == cdb_preg);
    assign hit_b = cdb_write && (port.opb_preg == cdb_preg);

    assign port.opa_ready = (port.opa_preg == '0) || hit_a || ready[port.opa_preg];
    assign port.opb_ready = (port.opb_preg == '0) || hit_b || ready[port.opb_preg];

    assign port.opa_value = (port.opa_preg == '0) ? '0 :
                            hit_a ? cdb_result : values[port.opa_preg];
    assign port.opb_value = (port.opb_preg == '0) ? '0 :
                            hit_b ? cdb_result : values[port.opb_preg];

    //////////////////////////////
    // state update
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            free  <= ~preg_mask_t'(1);   // all but reg 0
            ready <= '1;
            for (int i = 0; i < prf_size; i++) begin
                values[i] <= '0;
            end
        end else if (recovery.mis_pred) begin
            free  <= recovery.committed_free;
            ready <= ~recovery.committed_free | preg_mask_t'(1);
        end else begin
            if (recovery.release_valid) begin
                free[recovery.release_preg] <= 1'b1;   // stale mapping retired
            end
            if (port.alloc) begin
                free[lowest_free]  <= 1'b0;
                ready[lowest_free] <= 1'b0;           // waits for its broadcast
            end
            if (cdb_write) begin
                values[cdb_preg] <= cdb_result;
                ready[cdb_preg]  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/retire_map.sv
//////////////////////////////
// retirement map
// committed mapping and free set,
// commit release and recovery state
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module retire_map import rename_pkg::*; (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          commit_valid,
    input  wire areg_t         commit_dest,
    input  wire preg_t         commit_preg,
    input  wire logic          commit_mis_pred,
    recovery_if.retire_side    recovery
);

    preg_t [arch_size-1:0] comm_map;    // committed arch to phys map
    preg_mask_t            comm_free;

    preg_t stale_preg;
    logic  commit_take;
    logic  stale_release;

    //////////////////////////////
    // commit lookup
    //////////////////////////////

    // no commit to arch 0 or during a restore
    assign commit_take = commit_valid && (commit_dest != '0) && !commit_mis_pred;

    assign stale_preg    = comm_map[commit_dest];   // mapping being replaced
    assign stale_release = commit_take && (stale_preg != '0);

    assign recovery.release_valid  = stale_release;
    assign recovery.release_preg   = stale_preg;
    assign recovery.mis_pred       = commit_mis_pred;
    assign recovery.committed_free = comm_free;
    assign recovery.committed_map  = comm_map;

    //////////////////////////////
    // committed state
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            comm_map  <= '0;
            comm_free <= ~preg_mask_t'(1);
        end else if (commit_take) begin
            comm_map[commit_dest]  <= commit_preg;
            comm_free[commit_preg] <= 1'b0;
            if (stale_release) begin
                comm_free[stale_preg] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rename_core.sv
//////////////////////////////
// register rename core
// rename map, register file and retire map
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rename_core import rename_pkg::*; (
    input  wire logic   clock,
    input  wire logic   reset,
    // dispatch
    input  wire logic   dispatch_valid,
    input  wire areg_t  dispatch_dest,
    input  wire areg_t  dispatch_src_a,
    input  wire areg_t  dispatch_src_b,
    // completion bus
    input  wire logic   cdb_valid,
    input  wire preg_t  cdb_preg,
    input  wire word_t  cdb_result,
    // commit
    input  wire logic   commit_valid,
    input  wire areg_t  commit_dest,
    input  wire preg_t  commit_preg,
    input  wire logic   commit_mis_pred,
    // rename results
    output logic        dispatch_stall,
    output preg_t       dispatch_preg,
    output preg_t       opa_preg,
    output preg_t       opb_preg,
    output logic        opa_ready,
    output word_t       opa_value,
    output logic        opb_ready,
    output word_t       opb_value
);

    prf_port_if port_if ();
    recovery_if rec_if ();

    rename_map map_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .dispatch_src_a (dispatch_src_a),
        .dispatch_src_b (dispatch_src_b),
        .dispatch_stall (dispatch_stall),
        .dispatch_preg  (dispatch_preg),
        .port           (port_if.map_side),
        .recovery       (rec_if.map_side)
    );

    prf prf_i (
        .clock      (clock),
        .reset      (reset),
        .cdb_valid  (cdb_valid),
        .cdb_preg   (cdb_preg),
        .cdb_result (cdb_result),
        .port       (port_if.file_side),
        .recovery   (rec_if.file_side)
    );

    retire_map retire_i (
        .clock           (clock),
        .reset           (reset),
        .commit_valid    (commit_valid),
        .commit_dest     (commit_dest),
        .commit_preg     (commit_preg),
        .commit_mis_pred (commit_mis_pred),
        .recovery        (rec_if.retire_side)
    );

    // operand lookups straight off the file port
    assign opa_preg  = port_if.opa_preg;
    assign opb_preg  = port_if.opb_preg;
    assign opa_ready = port_if.opa_ready;
    assign opa_value = port_if.opa_value;
    assign opb_ready = port_if.opb_ready;
    assign opb_value = port_if.opb_value;

endmodule

`default_nettype wire

//--- bench/rename_model.svh
//////////////////////////////
// rename reference model
// model state, expected outputs, lfsr and check
//////////////////////////////
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

preg_t       m_spec [arch_size] = '{default: '0};
preg_t       m_comm [arch_size] = '{default: '0};
preg_mask_t  m_free      = 16'hfffe;   // all but reg 0
preg_mask_t  m_comm_free = 16'hfffe;
preg_mask_t  m_ready     = '1;
word_t       m_value [prf_size] = '{default: '0};
logic [31:0] lfsr_state  = 32'hfedb;
string       test_name   = "reset";

// lowest free register above 0, or 0 when none is left
function automatic preg_t next_free();
    for (int i = 1; i < prf_size; i++) begin
        if (m_free[i]) begin
            return preg_t'(i);
        end
    end
    return '0;
endfunction

function automatic logic exp_stall();
    return (dispatch_dest != '0) && (next_free() == '0);
endfunction

function automatic preg_t exp_dispatch_preg();
    return (dispatch_dest == '0) ? '0 : next_free();
endfunction

// broadcast seen by a read in the same cycle
function automatic logic cdb_hit(input preg_t p);
    return cdb_valid && (cdb_preg != '0) && !commit_mis_pred && (cdb_preg == p);
endfunction

function automatic logic exp_ready(input preg_t p);
    return (p == '0) || cdb_hit(p) || m_ready[p];
endfunction

function automatic word_t exp_value(input preg_t p);
    if (p == '0) begin
        return '0;
    end
    return cdb_hit(p) ? cdb_result : m_value[p];
endfunction

// galois lfsr, one step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return r;
endfunction

task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
        $display("Error %s %s expected %0h actual %0h", test_name, what, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "value mismatch");
    end
endtask

`endif

//--- bench/rename_core_tb.sv
//////////////////////////////
// rename core testbench
// directed and random dispatch, completion,
// commit and recovery against a reference model
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb
    import rename_pkg::*;
();

    localparam int period_ns     = 4;
    localparam int reset_cycles  = 4;
    localparam int direct_cycles = 60;
    localparam int random_cycles = 2000;
    localparam int timeout_ns    = (reset_cycles + direct_cycles + random_cycles) * period_ns + 200;

    logic  clock;
    logic  reset;
    logic  dispatch_valid;
    areg_t dispatch_dest;
    areg_t dispatch_src_a;
    areg_t dispatch_src_b;
    logic  cdb_valid;
    preg_t cdb_preg;
    word_t cdb_result;
    logic  commit_valid;
    areg_t commit_dest;
    preg_t commit_preg;
    logic  commit_mis_pred;
    logic  dispatch_stall;
    preg_t dispatch_preg;
    preg_t opa_preg;
    preg_t opb_preg;
    logic  opa_ready;
    word_t opa_value;
    logic  opb_ready;
    word_t opb_value;

    // in-flight instructions, oldest first
    areg_t      q_dest [$];
    preg_t      q_preg [$];
    preg_mask_t done = '0;

    `include "rename_model.svh"

    rename_core dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic idle_inputs();
        dispatch_valid  = 1'b0;
        dispatch_dest   = '0;
        dispatch_src_a  = '0;
        dispatch_src_b  = '0;
        cdb_valid       = 1'b0;
        cdb_preg        = '0;
        cdb_result      = '0;
        commit_valid    = 1'b0;
        commit_dest     = '0;
        commit_preg     = '0;
        commit_mis_pred = 1'b0;
    endtask

    task automatic next_cycle();
        @(negedge clock);
        idle_inputs();
    endtask

    task automatic dispatch(input logic valid, input areg_t dest, input areg_t sa, input areg_t sb);
        dispatch_valid = valid;
        dispatch_dest  = dest;
        dispatch_src_a = sa;
        dispatch_src_b = sb;
        if (valid && dest != '0 && next_free() != '0 && !commit_mis_pred) begin
            q_dest.push_back(dest);
            q_preg.push_back(next_free());
            done[next_free()] = 1'b0;
        end
    endtask

    task automatic broadcast(input preg_t p, input word_t value);
        cdb_valid  = 1'b1;
        cdb_preg   = p;
        cdb_result = value;
        done[p]    = 1'b1;
    endtask

    task automatic commit_head();
        commit_valid = 1'b1;
        commit_dest  = q_dest.pop_front();
        commit_preg  = q_preg.pop_front();
    endtask

    task automatic flush_queue();
        q_dest.delete();
        q_preg.delete();
        done = '0;
    endtask

    task automatic random_cycle();
        int    k;
        logic  v;
        areg_t d;
        areg_t a;
        areg_t b;
        commit_mis_pred = (rand_bits(6) == '0);   // rare restore
        if (q_preg.size() > 0 && done[q_preg[0]] && rand_bits(1) != '0) begin
            commit_head();
        end
        if (q_preg.size() > 0 && rand_bits(1) != '0) begin
            k = int'(rand_bits(4)) % q_preg.size();
            if (!done[q_preg[k]]) begin
                broadcast(q_preg[k], rand_bits(32));
            end
        end
        v = (rand_bits(2) != '0);
        d = areg_t'(rand_bits(3));
        a = areg_t'(rand_bits(3));
        b = areg_t'(rand_bits(3));
        dispatch(v, d, a, b);
        if (commit_mis_pred) begin
            flush_queue();
        end
    endtask

    //////////////////////////////
    // compare and model update
    //////////////////////////////

    task automatic compare_outputs();
        preg_t pa;
        preg_t pb;
        pa = m_spec[dispatch_src_a];
        pb = m_spec[dispatch_src_b];
        check("dispatch_stall", 32'(exp_stall()), 32'(dispatch_stall));
        check("dispatch_preg", 32'(exp_dispatch_preg()), 32'(dispatch_preg));
        check("opa_preg", 32'(pa), 32'(opa_preg));
        check("opb_preg", 32'(pb), 32'(opb_preg));
        check("opa_ready", 32'(exp_ready(pa)), 32'(opa_ready));
        check("opb_ready", 32'(exp_ready(pb)), 32'(opb_ready));
        check("opa_value", exp_value(pa), opa_value);
        check("opb_value", exp_value(pb), opb_value);
    endtask

    task automatic update_model();
        preg_t nf;
        preg_t stale;
        nf    = next_free();
        stale = m_comm[commit_dest];
        if (commit_mis_pred) begin
            m_spec  = m_comm;
            m_free  = m_comm_free;
            m_ready = ~m_comm_free | preg_mask_t'(1);
        end else begin
            if (dispatch_valid && dispatch_dest != '0 && nf != '0) begin
                m_spec[dispatch_dest] = nf;
                m_free[nf]  = 1'b0;
                m_ready[nf] = 1'b0;
            end
            if (commit_valid && commit_dest != '0) begin
                if (stale != '0) begin   // old mapping goes back to the pool
                    m_free[stale]      = 1'b1;
                    m_comm_free[stale] = 1'b1;
                end
                m_comm[commit_dest]      = commit_preg;
                m_comm_free[commit_preg] = 1'b0;
            end
            if (cdb_valid && cdb_preg != '0) begin
                m_value[cdb_preg] = cdb_result;
                m_ready[cdb_preg] = 1'b1;
            end
        end
    endtask

    // just before each rising edge
    always begin
        @(negedge clock);
        #1;
        if (!reset) begin
            compare_outputs();
            update_model();
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin
        reset = 1'b1;
        idle_inputs();
        repeat (reset_cycles) @(posedge clock);
        next_cycle();
        reset = 1'b0;

        test_name = "reset_state";
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            dispatch(1'b0, 3'd1, areg_t'(2 * i), areg_t'(2 * i + 1));
            #1;
            check("dispatch_preg", 32'd1, 32'(dispatch_preg));
            check("opa_ready", 32'd1, 32'(opa_ready));
            check("opb_value", 32'd0, opb_value);
        end

        test_name = "fill_free_set";
        for (int i = 0; i < 15; i++) begin
            next_cycle();
            dispatch(1'b1, areg_t'((i % 7) + 1), '0, '0);
            #1;
            check("dispatch_preg", 32'(i + 1), 32'(dispatch_preg));
        end
        repeat (2) begin   // held while stalled
            next_cycle();
            dispatch(1'b1, 3'd3, '0, '0);
            #1;
            check("dispatch_stall", 32'd1, 32'(dispatch_stall));
        end

        test_name = "completion_bypass";
        next_cycle();
        dispatch_src_a = 3'd2;   // arch 2 sits on reg 9
        #1;
        check("opa_ready", 32'd0, 32'(opa_ready));
        for (int p = 1; p < prf_size; p++) begin
            next_cycle();
            dispatch_src_a = 3'd2;
            broadcast(preg_t'(p), 32'hc0de_0000 | 32'(p));
            #1;
            if (p == 9) begin
                check("opa_ready", 32'd1, 32'(opa_ready));
                check("opa_value", 32'hc0de_0009, opa_value);
            end
        end
        next_cycle();
        dispatch_src_a = 3'd2;
        #1;
        check("opa_value", 32'hc0de_0009, opa_value);

        test_name = "commit_release";
        repeat (8) begin
            next_cycle();
            commit_head();
        end
        next_cycle();
        dispatch(1'b1, 3'd3, 3'd1, '0);
        #1;
        check("dispatch_preg", 32'd1, 32'(dispatch_preg));

        test_name = "mis_pred_recovery";
        next_cycle();
        commit_mis_pred = 1'b1;
        flush_queue();
        next_cycle();
        dispatch(1'b1, 3'd5, 3'd1, '0);
        #1;
        check("opa_preg", 32'd8, 32'(opa_preg));
        check("opa_value", 32'hc0de_0008, opa_value);
        check("dispatch_preg", 32'd1, 32'(dispatch_preg));
        next_cycle();
        dispatch(1'b1, 3'd6, '0, '0);
        #1;
        check("dispatch_preg", 32'd9, 32'(dispatch_preg));

        test_name = "random_mix";
        for (int c = 0; c < random_cycles; c++) begin
            next_cycle();
            random_cycle();
        end
        next_cycle();
        #2;
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
logic/rename_pkg.sv
logic/prf_port_if.sv
logic/recovery_if.sv
logic/rename_map.sv
logic/prf.sv
logic/retire_map.sv
logic/rename_core.sv
bench/rename_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = rename_core_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS      = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
